// File: design/sound_pkg.sv
package sound_pkg;

   // register map of pulse channel 1.
   localparam logic [15:0] addr_nr10 = 16'hff10;
   localparam logic [15:0] addr_nr11 = 16'hff11;
   localparam logic [15:0] addr_nr12 = 16'hff12;
   localparam logic [15:0] addr_nr13 = 16'hff13;
   localparam logic [15:0] addr_nr14 = 16'hff14;

   localparam int freq_w = 11; // frequency field and timer width.
   localparam int vol_w  = 4;  // volume and sample width.

   // length counter span, the nr11 length field covers 0 to len_max-1.
   localparam int len_max = 64;
   localparam int len_w   = $clog2(len_max);

   // wave patterns by duty code, bit n is the level at duty position n.
   localparam logic [7:0] duty_table [4] = '{
      8'b0000_0001,  // 12.5 %.
      8'b1000_0001,  // 25 %.
      8'b1000_0111,  // 50 %.
      8'b0111_1110   // 75 %.
   };

endpackage

// File: design/ch_ctrl_if.sv
`timescale 1ns/1ps

interface ch_ctrl_if;

   logic [2:0]                     sweep_time;
   logic                           sweep_decrease;
   logic [2:0]                     sweep_shift;
   logic [1:0]                     duty;
   logic [sound_pkg::len_w-1:0]    length_data;
   logic                           length_load;  // one cycle after an nr11 write.
   logic [sound_pkg::vol_w-1:0]    env_initial;
   logic                           env_increase;
   logic [2:0]                     env_period;
   logic [sound_pkg::freq_w-1:0]   base_freq;
   logic                           length_enable;
   logic                           trigger;      // one cycle after nr14 write with bit 7.

   modport regs (
      output sweep_time, sweep_decrease, sweep_shift, duty, length_data, length_load,
             env_initial, env_increase, env_period, base_freq, length_enable, trigger
   );

   modport chan (
      input  sweep_time, sweep_decrease, sweep_shift, duty, length_data, length_load,
             env_initial, env_increase, env_period, base_freq, length_enable, trigger
   );

endinterface

// File: design/sound_regs.sv
`timescale 1ns/1ps

module sound_regs (
   input  logic        I_CLK33MHZ,
   input  logic        I_RESET,
   input  logic [15:0] cpu_addr,
   input  logic [7:0]  cpu_wdata,
   input  logic        cpu_we,
   input  logic        cpu_re,
   output logic [7:0]  cpu_rdata,
   ch_ctrl_if.regs     ctrl
);

   logic [7:0] nr10, nr11, nr12, nr13, nr14;

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         nr10             <= 8'h00;
         nr11             <= 8'h00;
         nr12             <= 8'h00;
         nr13             <= 8'h00;
         nr14             <= 8'h00;
         ctrl.trigger     <= 1'b0;
         ctrl.length_load <= 1'b0;
      end else begin
         ctrl.trigger     <= cpu_we && (cpu_addr == sound_pkg::addr_nr14) && cpu_wdata[7];
         ctrl.length_load <= cpu_we && (cpu_addr == sound_pkg::addr_nr11);
         if (cpu_we) begin
            case (cpu_addr)
               sound_pkg::addr_nr10: nr10 <= cpu_wdata;
               sound_pkg::addr_nr11: nr11 <= cpu_wdata;
               sound_pkg::addr_nr12: nr12 <= cpu_wdata;
               sound_pkg::addr_nr13: nr13 <= cpu_wdata;
               sound_pkg::addr_nr14: nr14 <= cpu_wdata;
               default: ;
            endcase
         end
      end
   end

   // read data is held until the next read.
   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         cpu_rdata <= 8'h00;
      end else if (cpu_re) begin
         case (cpu_addr)
            sound_pkg::addr_nr10: cpu_rdata <= nr10;
            sound_pkg::addr_nr11: cpu_rdata <= nr11;
            sound_pkg::addr_nr12: cpu_rdata <= nr12;
            sound_pkg::addr_nr13: cpu_rdata <= nr13;
            sound_pkg::addr_nr14: cpu_rdata <= nr14;
            default:              cpu_rdata <= 8'hff; // unmapped.
         endcase
      end
   end

   assign ctrl.sweep_time     = nr10[6:4];
   assign ctrl.sweep_decrease = nr10[3];
   assign ctrl.sweep_shift    = nr10[2:0];
   assign ctrl.duty           = nr11[7:6];
   assign ctrl.length_data    = nr11[sound_pkg::len_w-1:0];
   assign ctrl.env_initial    = nr12[7:4];
   assign ctrl.env_increase   = nr12[3];
   assign ctrl.env_period     = nr12[2:0];
   assign ctrl.base_freq      = {nr14[2:0], nr13};  // high bits from nr14.
   assign ctrl.length_enable  = nr14[6];

endmodule

// File: design/frame_timer.sv
`timescale 1ns/1ps

module frame_timer #(
   parameter int FRAME_DIV = 128906
) (
   input  logic I_CLK33MHZ,
   input  logic I_RESET,
   output logic len_tick,
   output logic sweep_tick,
   output logic env_tick
);

   localparam int div_w = $clog2(FRAME_DIV + 1);

   logic [div_w-1:0] div_cnt;
   logic [1:0]       step;   // frame step within one envelope period.
   logic             wrap;

   assign wrap = (div_cnt == div_w'(FRAME_DIV - 1));

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         div_cnt    <= '0;
         step       <= 2'd0;
         len_tick   <= 1'b0;
         sweep_tick <= 1'b0;
         env_tick   <= 1'b0;
      end else begin
         len_tick   <= wrap;
         sweep_tick <= wrap && step[0];           // every second length tick.
         env_tick   <= wrap && (step == 2'd3);    // every fourth.
         if (wrap) begin
            div_cnt <= '0;
            step    <= step + 2'd1;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

// File: design/length_counter.sv
`timescale 1ns/1ps

module length_counter (
   input  logic    I_CLK33MHZ,
   input  logic    I_RESET,
   ch_ctrl_if.chan ctrl,
   input  logic    len_tick,
   output logic    ch_on
);

   localparam int cnt_w = $clog2(sound_pkg::len_max + 1);

   logic [cnt_w-1:0] count;
   logic             count_tick;

   assign count_tick = len_tick && ctrl.length_enable && (count != '0);

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         count <= '0;
         ch_on <= 1'b0;
      end else begin
         if (ctrl.trigger || ctrl.length_load) begin
            count <= cnt_w'(sound_pkg::len_max) - cnt_w'(ctrl.length_data);
         end else if (count_tick) begin
            count <= count - 1'b1;
         end

         // trigger wins over a coinciding last tick.
         if (ctrl.trigger) ch_on <= 1'b1;
         else if (count_tick && count == cnt_w'(1)) ch_on <= 1'b0;
      end
   end

endmodule

// File: design/freq_sweep.sv
`timescale 1ns/1ps

module freq_sweep (
   input  logic                         I_CLK33MHZ,
   input  logic                         I_RESET,
   ch_ctrl_if.chan                      ctrl,
   input  logic                         sweep_tick,
   output logic [sound_pkg::freq_w-1:0] freq
);

   localparam int fw = sound_pkg::freq_w;

   logic [2:0]  sweep_cnt;
   logic [fw-1:0] delta;
   logic [fw:0]   stepped;   // extra bit flags an overflow.

   assign delta   = freq >> ctrl.sweep_shift;
   assign stepped = ctrl.sweep_decrease ? {1'b0, freq} - {1'b0, delta}
                                        : {1'b0, freq} + {1'b0, delta};

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         freq      <= '0;
         sweep_cnt <= 3'd0;
      end else if (ctrl.trigger) begin
         freq      <= ctrl.base_freq;
         sweep_cnt <= 3'd0;
      end else if (sweep_tick && ctrl.sweep_time != 3'd0) begin
         if (sweep_cnt == ctrl.sweep_time - 3'd1) begin
            sweep_cnt <= 3'd0;
            if (!stepped[fw])
               freq <= stepped[fw-1:0];  // an overflowing step keeps the old value.
         end else begin
            sweep_cnt <= sweep_cnt + 3'd1;
         end
      end
   end

endmodule

// File: design/volume_envelope.sv
`timescale 1ns/1ps

module volume_envelope (
   input  logic                        I_CLK33MHZ,
   input  logic                        I_RESET,
   ch_ctrl_if.chan                     ctrl,
   input  logic                        env_tick,
   output logic [sound_pkg::vol_w-1:0] volume
);

   logic [2:0] env_cnt;

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         volume  <= '0;
         env_cnt <= 3'd0;
      end else if (ctrl.trigger) begin
         volume  <= ctrl.env_initial;
         env_cnt <= 3'd0;
      end else if (env_tick && ctrl.env_period != 3'd0) begin // period 0 holds the volume.
         if (env_cnt == ctrl.env_period - 3'd1) begin
            env_cnt <= 3'd0;
            if (ctrl.env_increase && volume != '1)
               volume <= volume + 1'b1;
            else if (!ctrl.env_increase && volume != '0)
               volume <= volume - 1'b1;
         end else begin
            env_cnt <= env_cnt + 3'd1;
         end
      end
   end

endmodule

// File: design/square_gen.sv
`timescale 1ns/1ps

module square_gen #(
   parameter int FREQ_DIV = 8
) (
   input  logic                         I_CLK33MHZ,
   input  logic                         I_RESET,
   ch_ctrl_if.chan                      ctrl,
   input  logic [sound_pkg::freq_w-1:0] freq,
   input  logic [sound_pkg::vol_w-1:0]  volume,
   input  logic                         ch_on,
   output logic [sound_pkg::vol_w-1:0]  sample,
   output logic                         sample_valid,
   input  logic                         sample_ready
);

   localparam int pre_w = $clog2(FREQ_DIV + 1);

   logic [pre_w-1:0]              pre_cnt;
   logic [sound_pkg::freq_w-1:0]  timer;     // counts up from freq to all ones.
   logic [2:0]                    duty_pos;
   logic [sound_pkg::vol_w-1:0]   sample_r;
   logic                          stall;
   logic                          pre_tick;
   logic                          advance;
   logic                          new_sample;
   logic                          duty_bit;

   assign stall      = sample_valid && !sample_ready;  // pending sample not yet taken.
   assign pre_tick   = !stall && (pre_cnt == pre_w'(FREQ_DIV - 1));
   assign advance    = pre_tick && (timer == '1);
   assign new_sample = advance && !ctrl.trigger;
   assign duty_bit   = sound_pkg::duty_table[ctrl.duty][duty_pos];

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET) begin
         pre_cnt      <= '0;
         timer        <= '0;
         duty_pos     <= 3'd0;
         sample_valid <= 1'b0;
      end else begin
         if (ctrl.trigger) begin
            // restart the waveform from the new base frequency.
            pre_cnt  <= '0;
            timer    <= ctrl.base_freq;
            duty_pos <= 3'd0;
         end else if (!stall) begin
            pre_cnt <= pre_tick ? '0 : pre_cnt + 1'b1;
            if (pre_tick)
               timer <= (timer == '1) ? freq : timer + 1'b1;
            if (advance)
               duty_pos <= duty_pos + 3'd1;
         end

         if (new_sample) sample_valid <= 1'b1;
         else if (sample_ready) sample_valid <= 1'b0;
      end
   end

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_RESET)
         sample_r <= '0;
      else if (new_sample)
         sample_r <= (duty_bit && ch_on) ? volume : '0;
   end

   assign sample = ch_on ? sample_r : '0;  // silent once the channel stops.

endmodule

// File: design/sound_channel1.sv
`timescale 1ns/1ps

module sound_channel1 #(
   parameter int FRAME_DIV = 128906,  // clocks per length tick, 256 Hz.
   parameter int FREQ_DIV  = 8
) (
   input  logic                        I_CLK33MHZ,
   input  logic                        I_RESET,
   input  logic [15:0]                 cpu_addr,
   input  logic [7:0]                  cpu_wdata,
   input  logic                        cpu_we,
   input  logic                        cpu_re,
   output logic [7:0]                  cpu_rdata,
   output logic [sound_pkg::vol_w-1:0] sample,
   output logic                        sample_valid,
   input  logic                        sample_ready,
   output logic                        ch1_on
);

   logic                         len_tick;
   logic                         sweep_tick;
   logic                         env_tick;
   logic [sound_pkg::freq_w-1:0] freq;
   logic [sound_pkg::vol_w-1:0]  volume;

   ch_ctrl_if ctrl ();

   sound_regs u_regs (
      .I_CLK33MHZ (I_CLK33MHZ),
      .I_RESET    (I_RESET),
      .cpu_addr   (cpu_addr),
      .cpu_wdata  (cpu_wdata),
      .cpu_we     (cpu_we),
      .cpu_re     (cpu_re),
      .cpu_rdata  (cpu_rdata),
      .ctrl       (ctrl.regs)
   );

   frame_timer #(.FRAME_DIV(FRAME_DIV)) u_frame (
      .I_CLK33MHZ (I_CLK33MHZ),
      .I_RESET    (I_RESET),
      .len_tick   (len_tick),
      .sweep_tick (sweep_tick),
      .env_tick   (env_tick)
   );

   length_counter u_length (
      .I_CLK33MHZ (I_CLK33MHZ),
      .I_RESET    (I_RESET),
      .ctrl       (ctrl.chan),
      .len_tick   (len_tick),
      .ch_on      (ch1_on)
   );

   freq_sweep u_sweep (
      .I_CLK33MHZ (I_CLK33MHZ),
      .I_RESET    (I_RESET),
      .ctrl       (ctrl.chan),
      .sweep_tick (sweep_tick),
      .freq       (freq)
   );

   volume_envelope u_env (
      .I_CLK33MHZ (I_CLK33MHZ),
      .I_RESET    (I_RESET),
      .ctrl       (ctrl.chan),
      .env_tick   (env_tick),
      .volume     (volume)
   );

   square_gen #(.FREQ_DIV(FREQ_DIV)) u_square (
      .I_CLK33MHZ   (I_CLK33MHZ),
      .I_RESET      (I_RESET),
      .ctrl         (ctrl.chan),
      .freq         (freq),
      .volume       (volume),
      .ch_on        (ch1_on),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready)
   );

endmodule

// File: test/tb_sound_channel1_asserts.sv
`timescale 1ns/1ps

module tb_sound_channel1_asserts (
   input logic       I_CLK33MHZ,
   input logic       I_RESET,
   input logic [3:0] sample,
   input logic       sample_valid,
   input logic       sample_ready,
   input logic       ch_on
);

   // a pending sample holds while the channel stays on.
   sample_stable: assert property (@(posedge I_CLK33MHZ) disable iff (I_RESET)
      (sample_valid && !sample_ready && ch_on) |=> (sample == $past(sample)) || !ch_on)
      else $error("sample changed while waiting for ready");

   valid_in_reset: assert property (@(posedge I_CLK33MHZ)
      I_RESET |=> !sample_valid)
      else $error("sample_valid high during reset");

   silent_when_off: assert property (@(posedge I_CLK33MHZ) disable iff (I_RESET)
      !ch_on |-> (sample == 4'd0))
      else $error("nonzero sample with the channel off");

endmodule

bind square_gen tb_sound_channel1_asserts u_asserts (
   .I_CLK33MHZ   (I_CLK33MHZ),
   .I_RESET      (I_RESET),
   .sample       (sample),
   .sample_valid (sample_valid),
   .sample_ready (sample_ready),
   .ch_on        (ch_on)
);

// File: test/tb_sound_channel1.sv
`timescale 1ns/1ps

module tb_sound_channel1;

   localparam int frame_div  = 40;
   localparam int freq_div   = 1;
   localparam int rb_len     = 60;
   localparam int duty_len   = 16 * 8 + 40;
   localparam int length_len = 64 * frame_div;
   localparam int env_len    = 48 * 16 + 40;
   localparam int sweep_len  = 4000;
   localparam int bp_len     = 24 * 8 * 4;
   localparam int max_cycles = 2 * (rb_len + 4 * duty_len + length_len + 2 * env_len
                                    + sweep_len + bp_len);

   logic        I_CLK33MHZ = 1'b0;
   logic        I_RESET;
   logic [15:0] cpu_addr;
   logic [7:0]  cpu_wdata;
   logic        cpu_we;
   logic        cpu_re;
   logic [7:0]  cpu_rdata;
   logic [3:0]  sample;
   logic        sample_valid;
   logic        sample_ready;
   logic        ch1_on;

   int   seed = 32'hcbde;
   int   rnd;
   int   cycle_cnt = 0;
   int   errors = 0;
   int   checks = 0;
   int   tests = 0;
   bit   ready_random = 0;
   bit   checking = 0;
   int   cur_duty, cur_vol, cur_period;
   bit   cur_inc;
   int   accepted = 0;
   int   env_ticks = 0;
   int   ticks_before_prev = 0;
   int   cap_ticks = 0;
   bit   prev_valid = 0;
   logic [3:0] exp_s;

   sound_channel1 #(.FRAME_DIV(frame_div), .FREQ_DIV(freq_div)) uut (
      .I_CLK33MHZ   (I_CLK33MHZ),
      .I_RESET      (I_RESET),
      .cpu_addr     (cpu_addr),
      .cpu_wdata    (cpu_wdata),
      .cpu_we       (cpu_we),
      .cpu_re       (cpu_re),
      .cpu_rdata    (cpu_rdata),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready),
      .ch1_on       (ch1_on)
   );

   always #10 I_CLK33MHZ = ~I_CLK33MHZ;

   always @(posedge I_CLK33MHZ) begin
      cycle_cnt++;
      if (cycle_cnt > max_cycles) begin
         $display("timeout: run exceeded %0d cycles", max_cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   always @(posedge I_CLK33MHZ) begin
      #2;
      rnd = $random(seed);
      sample_ready = ready_random ? rnd[0] : 1'b1;
   end

   // expected level per duty position with the envelope stepped by ticks since trigger.
   function automatic logic [3:0] expected_sample(input int duty, input int k, input int vol,
                                                  input bit inc, input int period,
                                                  input int ticks);
      logic [7:0] pattern;
      int         level;
      case (duty)
         0:       pattern = 8'b0000_0001;
         1:       pattern = 8'b1000_0001;
         2:       pattern = 8'b1000_0111;
         default: pattern = 8'b0111_1110;
      endcase
      level = vol;
      if (period != 0) level = inc ? vol + ticks / period : vol - ticks / period;
      if (level > 15) level = 15;
      if (level < 0) level = 0;
      return pattern[k % 8] ? 4'(level) : 4'd0;
   endfunction

   function automatic int next_freq(input int f, input int shift, input bit dec);
      int n;
      n = dec ? f - (f >> shift) : f + (f >> shift);
      return (n > 2047) ? f : n; // overflow keeps the frequency.
   endfunction

   // the capture tick count is taken at the rise of valid.
   always @(posedge I_CLK33MHZ) begin
      if (sample_valid && !prev_valid) cap_ticks = ticks_before_prev;
      ticks_before_prev = env_ticks;
      if (uut.env_tick) env_ticks++;
      prev_valid = sample_valid;
      if (checking && sample_valid && sample_ready) begin
         exp_s = expected_sample(cur_duty, accepted, cur_vol, cur_inc, cur_period, cap_ticks);
         checks++;
         if (sample !== exp_s) begin
            errors++;
            $display("mismatch at %0t: sample expected %0d got %0d", $time, exp_s, sample);
         end
         accepted++;
      end
   end

   task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
      @(posedge I_CLK33MHZ);
      #2;
      cpu_addr  = addr;
      cpu_wdata = data;
      cpu_we    = 1'b1;
      @(posedge I_CLK33MHZ);
      #2;
      cpu_we = 1'b0;
   endtask

   task automatic check_read(input logic [15:0] addr, input logic [7:0] exp);
      @(posedge I_CLK33MHZ);
      #2;
      cpu_addr = addr;
      cpu_re   = 1'b1;
      @(posedge I_CLK33MHZ);
      #2;
      cpu_re = 1'b0;
      checks++;
      if (cpu_rdata !== exp) begin
         errors++;
         $display("mismatch at %0t: cpu_rdata expected %h got %h", $time, exp, cpu_rdata);
      end
   endtask

   // returns one cycle after the trigger reached the channel units.
   task automatic start_channel(input logic [7:0] nr10, input logic [7:0] nr11,
                                input logic [7:0] nr12, input logic [10:0] f,
                                input bit len_en);
      write_reg(sound_pkg::addr_nr10, nr10);
      write_reg(sound_pkg::addr_nr11, nr11);
      write_reg(sound_pkg::addr_nr12, nr12);
      write_reg(sound_pkg::addr_nr13, f[7:0]);
      write_reg(sound_pkg::addr_nr14, {1'b1, len_en, 3'b000, f[10:8]});
      @(posedge I_CLK33MHZ);
      #2;
   endtask

   task automatic run_wave(input int duty, input int vol, input bit inc, input int period,
                           input int f, input int n, input bit random_ready);
      checking     = 0;
      ready_random = 0;
      cur_duty     = duty;
      cur_vol      = vol;
      cur_inc      = inc;
      cur_period   = period;
      start_channel(8'h00, 8'(duty << 6), {4'(vol), inc, 3'(period)}, 11'(f), 0);
      accepted          = 0;
      env_ticks         = 0;
      ticks_before_prev = 0;
      cap_ticks         = 0;
      checking          = 1;
      ready_random      = random_ready;
      while (accepted < n) @(posedge I_CLK33MHZ);
      #2;
      checking     = 0;
      ready_random = 0;
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      $display("%s: done, %0d errors", name, errors - errors_before);
   endtask

   task automatic length_test();
      int n;
      int e0;
      e0 = errors;
      checks++;
      if (ch1_on !== 1'b0) begin
         errors++;
         $display("ch1_on was already high before the trigger at %0t", $time);
      end
      start_channel(8'h00, 8'h80 | 8'd60, 8'hf0, 11'd2040, 1);
      checks++;
      if (ch1_on !== 1'b1) begin
         errors++;
         $display("ch1_on did not rise one cycle after the trigger at %0t", $time);
      end
      n = 1;
      while (ch1_on && n < length_len) begin
         @(posedge I_CLK33MHZ);
         #2;
         n++;
      end
      checks++;
      if (n < 3 * frame_div || n > 4 * frame_div + 2) begin
         errors++;
         $display("ch1_on fell %0d cycles after the trigger, outside the length window", n);
      end
      repeat (40) begin
         @(posedge I_CLK33MHZ);
         #2;
         if (sample_valid && sample !== 4'd0) begin
            errors++;
            $display("mismatch at %0t: sample expected 0 got %0d", $time, sample);
         end
      end
      report_test("length stop", e0);
   endtask

   task automatic sweep_test();
      int refs[$];
      int f, p, q, sp, last_rise, cyc, at_end, e0;
      bit prev, found;
      e0 = errors;
      f  = 1200;
      refs.push_back(f);
      while (next_freq(f, 2, 0) != f) begin
         f = next_freq(f, 2, 0);
         refs.push_back(f);
      end
      start_channel(8'h22, 8'h80, 8'hf0, 11'd1200, 0);
      p = 0;
      last_rise = -1;
      cyc = 0;
      at_end = 0;
      prev = 0;
      while (at_end < 4 && cyc < sweep_len) begin
         @(posedge I_CLK33MHZ);
         #1;
         cyc++;
         if (sample_valid && !prev) begin
            if (last_rise >= 0) begin
               sp = cyc - last_rise;
               found = 0;
               for (q = p; q < refs.size(); q++) begin
                  if (!found && sp == 2048 - refs[q]) begin
                     found = 1;
                     p = q;
                  end
               end
               checks++;
               if (!found) begin
                  errors++;
                  $display("mismatch at %0t: sample_valid spacing expected %0d got %0d",
                           $time, 2048 - refs[p], sp);
               end
               if (p == refs.size() - 1) at_end++;
            end
            last_rise = cyc;
         end
         prev = sample_valid;
      end
      if (at_end < 4) begin
         errors++;
         $display("sweep never settled at frequency %0d after the overflow step", refs[$]);
      end
      report_test("sweep", e0);
   endtask

   initial begin
      int e0;
      I_RESET      = 1'b1;
      cpu_addr     = 16'h0000;
      cpu_wdata    = 8'h00;
      cpu_we       = 1'b0;
      cpu_re       = 1'b0;
      sample_ready = 1'b1;
      repeat (3) @(posedge I_CLK33MHZ);
      #2;
      I_RESET = 1'b0;

      e0 = errors;
      write_reg(sound_pkg::addr_nr10, 8'h7a);
      write_reg(sound_pkg::addr_nr11, 8'hc5);
      write_reg(sound_pkg::addr_nr12, 8'h93);
      write_reg(sound_pkg::addr_nr13, 8'h3c);
      write_reg(sound_pkg::addr_nr14, 8'h45);
      check_read(sound_pkg::addr_nr10, 8'h7a);
      check_read(sound_pkg::addr_nr11, 8'hc5);
      check_read(sound_pkg::addr_nr12, 8'h93);
      check_read(sound_pkg::addr_nr13, 8'h3c);
      check_read(sound_pkg::addr_nr14, 8'h45);
      check_read(16'hff15, 8'hff);
      report_test("register read-back", e0);

      // the channel is still off here, so the rise of ch1_on is visible.
      length_test();

      e0 = errors;
      for (int d = 0; d < 4; d++) run_wave(d, 10, 0, 0, 2040, 16, 0);
      report_test("duty and volume", e0);

      e0 = errors;
      run_wave(3, 13, 1, 1, 2032, 48, 0);
      run_wave(3, 2, 0, 1, 2032, 48, 0);
      report_test("envelope", e0);

      sweep_test();

      e0 = errors;
      run_wave(2, 7, 0, 0, 2040, 24, 1);
      report_test("back-pressure", e0);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: vlog.f
design/sound_pkg.sv
design/ch_ctrl_if.sv
design/sound_regs.sv
design/frame_timer.sv
design/length_counter.sv
design/freq_sweep.sv
design/volume_envelope.sv
design/square_gen.sv
design/sound_channel1.sv
test/tb_sound_channel1_asserts.sv
test/tb_sound_channel1.sv
